// File: sim.f
+incdir+.
mm_cfg_pkg.sv
mm_ctrl_pkg.sv
mm_regfile.sv
mm_tiler.sv
mm_ctrl.sv
mm_engine.sv
mm_accel_top.sv
mm_accel_sva.sv
tb_mm_accel.sv

// File: tb_mm_accel.sv
// Matrix accelerator testbench
`include "mm_consts.svh"

module tb_mm_accel;

  localparam int BusyTimeout = 40;
  localparam int DoneTimeout = 300;

  logic                     clk_i;
  logic                     rst_ni;
  mm_ctrl_pkg::periph_req_t periph_req;
  mm_ctrl_pkg::periph_rsp_t periph_rsp;
  logic                     busy;
  logic                     evt_done;
  logic                     clear;

  int   seed         = 68;
  int   err_cnt      = 0;
  int   done_cnt     = 0;
  int   tests_run    = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  logic busy_prev    = 1'b0;
  logic latch_seen   = 1'b0;
  logic aborted      = 1'b0;

  mm_accel_top dut0 (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp ),
    .busy_o       ( busy       ),
    .evt_done_o   ( evt_done   ),
    .clear_o      ( clear      )
  );

  always #10 clk_i = ~clk_i;

  // Done counter and per-cycle event checks
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (evt_done) begin
        done_cnt++;
        // Busy drops in the same cycle the done event rises
        assert (!busy && busy_prev) else begin
          $display("Error at %0t: busy did not fall with the done event", $time);
          err_cnt++;
        end
      end
      // Clear pulses together with the done event after the reset latch
      if (latch_seen) begin
        assert (clear == evt_done) else begin
          $display("Error at %0t: clear is %0b while the done event is %0b",
                   $time, clear, evt_done);
          err_cnt++;
        end
      end
      latch_seen = 1'b1;
      busy_prev  = busy;
    end
  end

  // Reference tiling from the ceiling and remainder rules
  function automatic mm_cfg_pkg::mm_config_t model_config(input mm_cfg_pkg::dim_t m,
      input mm_cfg_pkg::dim_t n, input mm_cfg_pkg::dim_t k, input mm_cfg_pkg::red_op_e red);
    mm_cfg_pkg::mm_config_t c;
    int xt;
    int wt;
    int kt;
    int rem;
    c        = '0;
    c.m_size = m;
    c.n_size = n;
    c.k_size = k;
    c.red_op = red;
    xt = (int'(m) + `MM_WIDTH - 1) / `MM_WIDTH;
    wt = (int'(n) + `MM_TILE - 1) / `MM_TILE;
    kt = (int'(k) + `MM_HEIGHT - 1) / `MM_HEIGHT;
    c.x_tiles = xt[`MM_SIZE_W-1:0];
    c.w_tiles = wt[`MM_SIZE_W-1:0];
    c.k_tiles = kt[`MM_SIZE_W-1:0];
    xt = xt * wt;
    c.total_tiles = xt[`MM_SIZE_W-1:0];
    rem = int'(m) % `MM_WIDTH;
    c.m_left = rem[$clog2(`MM_WIDTH)-1:0];
    rem = int'(n) % `MM_TILE;
    c.n_left = rem[$clog2(`MM_TILE)-1:0];
    rem = int'(k) % `MM_HEIGHT;
    c.k_left = rem[$clog2(`MM_HEIGHT)-1:0];
    return c;
  endfunction

  // Sizes in 1..64
  function automatic mm_cfg_pkg::dim_t rand_dim();
    int r;
    r = $random(seed);
    return mm_cfg_pkg::dim_t'((r & 63) + 1);
  endfunction

  function automatic mm_cfg_pkg::red_op_e rand_red();
    int         r;
    logic [1:0] v;
    r = $random(seed);
    v = 2'((r & 32'h7fff_ffff) % 3);
    return mm_cfg_pkg::red_op_e'(v);
  endfunction

  task automatic check_eq(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // One-cycle write strobe
  task automatic write_reg(input mm_ctrl_pkg::reg_addr_t addr,
      input mm_ctrl_pkg::reg_data_t data);
    @(posedge clk_i);
    periph_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk_i);
    periph_req <= '0;
  endtask

  // Answer is due on the cycle after the strobe
  task automatic read_reg(input mm_ctrl_pkg::reg_addr_t addr,
      output mm_ctrl_pkg::reg_data_t data);
    @(posedge clk_i);
    periph_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clk_i);
    periph_req <= '0;
    @(negedge clk_i);
    assert (periph_rsp.valid) else begin
      $display("Error at %0t: no read response for register %0d", $time, addr);
      err_cnt++;
    end
    data = periph_rsp.rdata;
  endtask

  task automatic program_job(input mm_cfg_pkg::dim_t m, input mm_cfg_pkg::dim_t n,
      input mm_cfg_pkg::dim_t k, input mm_cfg_pkg::red_op_e red);
    write_reg(`MM_REG_M, 32'(m));
    write_reg(`MM_REG_N, 32'(n));
    write_reg(`MM_REG_K, 32'(k));
    write_reg(`MM_REG_RED, 32'(red));
  endtask

  task automatic trigger_job();
    write_reg(`MM_REG_TRIGGER, 32'd1);
  endtask

  task automatic wait_busy();
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
    end while (!busy && cyc < BusyTimeout);
    if (!busy) begin
      $display("Timeout: busy never rose within %0d cycles of the trigger", BusyTimeout);
      aborted = 1'b1;
    end
  endtask

  // Counter moves on the falling edge, so look on the rising one
  task automatic wait_done(input int target);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk_i);
      cyc++;
    end while (done_cnt < target && cyc < DoneTimeout);
    if (done_cnt < target) begin
      $display("Timeout: no done event arrived within %0d cycles", DoneTimeout);
      aborted = 1'b1;
    end
  endtask

  // Full job with one done event and the tile count
  task automatic run_job(input mm_cfg_pkg::dim_t m, input mm_cfg_pkg::dim_t n,
      input mm_cfg_pkg::dim_t k, input mm_cfg_pkg::red_op_e red);
    mm_cfg_pkg::mm_config_t exp_cfg;
    mm_ctrl_pkg::reg_data_t rd;
    int                     base;
    exp_cfg = model_config(m, n, k, red);
    program_job(m, n, k, red);
    base = done_cnt;
    trigger_job();
    wait_busy();
    if (aborted) return;
    wait_done(base + 1);
    if (aborted) return;
    // Quiet window where a second pulse would show up
    repeat (8) @(posedge clk_i);
    check_eq("done events for one job", done_cnt - base, 1);
    read_reg(`MM_REG_TILES, rd);
    check_eq("tile count", int'(rd), int'(exp_cfg.total_tiles));
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before && !aborted) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed", name);
    end
  endtask

  task automatic reset_test();
    mm_ctrl_pkg::reg_data_t rd;
    int                     errs;
    errs = err_cnt;
    @(negedge clk_i);
    check_eq("busy after reset", int'(busy), 0);
    check_eq("done event after reset", int'(evt_done), 0);
    check_eq("clear in reset latch", int'(clear), 1);
    read_reg(`MM_REG_STATUS, rd);
    check_eq("status busy bit", int'(rd[0]), 0);
    report_test("reset", errs);
  endtask

  task automatic regfile_test();
    mm_cfg_pkg::dim_t       m;
    mm_cfg_pkg::dim_t       n;
    mm_cfg_pkg::dim_t       k;
    mm_cfg_pkg::red_op_e    red;
    mm_ctrl_pkg::reg_data_t rd;
    int                     errs;
    errs = err_cnt;
    m    = rand_dim();
    n    = rand_dim();
    k    = rand_dim();
    red  = rand_red();
    program_job(m, n, k, red);
    read_reg(`MM_REG_M, rd);
    check_eq("M register", int'(rd), int'(m));
    read_reg(`MM_REG_N, rd);
    check_eq("N register", int'(rd), int'(n));
    read_reg(`MM_REG_K, rd);
    check_eq("K register", int'(rd), int'(k));
    read_reg(`MM_REG_RED, rd);
    check_eq("reduction register", int'(rd), int'(red));
    report_test("register read-back", errs);
  endtask

  task automatic random_jobs_test();
    int errs;
    errs = err_cnt;
    for (int i = 0; i < 4 && !aborted; i++) begin
      run_job(rand_dim(), rand_dim(), rand_dim(), rand_red());
    end
    report_test("random jobs", errs);
  endtask

  task automatic reduction_test();
    int errs;
    errs = err_cnt;
    run_job(rand_dim(), rand_dim(), rand_dim(), mm_cfg_pkg::RED_SUM);
    if (!aborted) begin
      run_job(rand_dim(), rand_dim(), rand_dim(), mm_cfg_pkg::RED_MAX);
    end
    report_test("reduction modes", errs);
  endtask

  task automatic sticky_done_test();
    mm_ctrl_pkg::reg_data_t rd;
    int                     errs;
    errs = err_cnt;
    // Drop any done bit left by earlier jobs
    read_reg(`MM_REG_STATUS, rd);
    read_reg(`MM_REG_STATUS, rd);
    check_eq("status done bit before job", int'(rd[1]), 0);
    run_job(rand_dim(), rand_dim(), rand_dim(), rand_red());
    if (!aborted) begin
      read_reg(`MM_REG_STATUS, rd);
      check_eq("status done bit after job", int'(rd[1]), 1);
      check_eq("status busy bit after job", int'(rd[0]), 0);
      read_reg(`MM_REG_STATUS, rd);
      check_eq("status done bit on second read", int'(rd[1]), 0);
    end
    report_test("done sticky", errs);
  endtask

  // Long first job with the second one programmed and triggered under it
  task automatic back_to_back_test();
    mm_cfg_pkg::mm_config_t cfg_a;
    mm_cfg_pkg::mm_config_t cfg_b;
    mm_ctrl_pkg::reg_data_t rd;
    int                     base;
    int                     errs;
    errs  = err_cnt;
    cfg_a = model_config(16'd64, 16'd64, 16'd64, mm_cfg_pkg::RED_SUM);
    cfg_b = model_config(rand_dim(), rand_dim(), rand_dim(), rand_red());
    program_job(cfg_a.m_size, cfg_a.n_size, cfg_a.k_size, cfg_a.red_op);
    base = done_cnt;
    trigger_job();
    wait_busy();
    if (!aborted) begin
      program_job(cfg_b.m_size, cfg_b.n_size, cfg_b.k_size, cfg_b.red_op);
      @(negedge clk_i);
      assert (busy) else begin
        $display("Error at %0t: first job ended before the second trigger", $time);
        err_cnt++;
      end
      trigger_job();
      wait_done(base + 1);
    end
    if (!aborted) begin
      read_reg(`MM_REG_TILES, rd);
      check_eq("first job tile count", int'(rd), int'(cfg_a.total_tiles));
      wait_done(base + 2);
    end
    if (!aborted) begin
      read_reg(`MM_REG_TILES, rd);
      check_eq("second job tile count", int'(rd), int'(cfg_b.total_tiles));
      repeat (8) @(posedge clk_i);
      check_eq("done events for two jobs", done_cnt - base, 2);
    end
    report_test("back-to-back", errs);
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    periph_req = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_test();
    if (!aborted) regfile_test();
    if (!aborted) random_jobs_test();
    if (!aborted) reduction_test();
    if (!aborted) sticky_done_test();
    if (!aborted) back_to_back_test();
    $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0 && !aborted) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: mm_accel_sva.sv
// Controller state checks
module mm_accel_sva (
  input logic                     clk_i,
  input logic                     rst_ni,
  input mm_ctrl_pkg::ctrl_state_e state_i,
  input logic                     busy_i,
  input logic                     evt_done_i,
  input logic                     clear_i
);

  // Idle never reports busy
  a_idle_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == mm_ctrl_pkg::ST_IDLE) |-> !busy_i)
    else $error("busy high while the controller is idle");

  // Finish state is a single cycle
  a_finish_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == mm_ctrl_pkg::ST_FINISHED) |=> (state_i != mm_ctrl_pkg::ST_FINISHED))
    else $error("finished state held for more than one cycle");

  // Done event and clear pulse coincide once out of the reset latch
  a_done_is_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i != mm_ctrl_pkg::ST_LATCH_RST) |-> (evt_done_i == clear_i))
    else $error("done event and clear pulse differ");

endmodule

bind mm_ctrl mm_accel_sva sva0 (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .state_i    ( state_q    ),
  .busy_i     ( busy_o     ),
  .evt_done_i ( evt_done_o ),
  .clear_i    ( clear_o    )
);

// File: mm_accel_top.sv
// Matrix accelerator control top
module mm_accel_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  mm_ctrl_pkg::periph_req_t periph_req_i,
  output mm_ctrl_pkg::periph_rsp_t periph_rsp_o,
  output logic                     busy_o,
  output logic                     evt_done_o,
  output logic                     clear_o
);

  // Controller and engine exchange
  mm_cfg_pkg::mm_config_t     job_config;
  mm_cfg_pkg::tile_cnt_t      tiles;
  mm_ctrl_pkg::sched_ctrl_t   sched;
  mm_ctrl_pkg::stream_flags_t flags;
  logic                       w_loaded;

  mm_ctrl i_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .w_loaded_i   ( w_loaded     ),
    .flags_i      ( flags        ),
    .tiles_i      ( tiles        ),
    .config_o     ( job_config   ),
    .sched_o      ( sched        ),
    .busy_o       ( busy_o       ),
    .clear_o      ( clear_o      ),
    .evt_done_o   ( evt_done_o   )
  );

  mm_engine i_engine (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .config_i   ( job_config ),
    .sched_i    ( sched      ),
    .w_loaded_o ( w_loaded   ),
    .flags_o    ( flags      ),
    .tiles_o    ( tiles      )
  );

endmodule

// File: mm_engine.sv
// Datapath stand-in
module mm_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mm_cfg_pkg::mm_config_t     config_i,
  input  mm_ctrl_pkg::sched_ctrl_t   sched_i,
  output logic                       w_loaded_o,
  output mm_ctrl_pkg::stream_flags_t flags_o,
  output mm_cfg_pkg::tile_cnt_t      tiles_o
);

  mm_cfg_pkg::tile_cnt_t w_cnt_q;
  mm_cfg_pkg::tile_cnt_t w_cnt_next;
  mm_cfg_pkg::tile_cnt_t tile_cnt_q;
  logic                  w_seen_q;
  logic                  w_loaded_q;
  logic                  z_done_q;
  logic                  r_done_q;
  logic                  count_en;

  assign w_cnt_next = w_cnt_q + 1'b1;
  // Tiles flow once weights are in and first_load has dropped
  assign count_en   = w_seen_q & ~sched_i.first_load & ~z_done_q;

  // Weight load, one K tile per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt_q    <= '0;
      w_seen_q   <= 1'b0;
      w_loaded_q <= 1'b0;
    end else if (sched_i.rst) begin
      w_cnt_q    <= '0;
      w_seen_q   <= 1'b0;
      w_loaded_q <= 1'b0;
    end else begin
      w_loaded_q <= 1'b0;
      if (sched_i.first_load && !w_seen_q) begin
        w_cnt_q <= w_cnt_next;
        if (w_cnt_next >= config_i.k_tiles) begin
          w_seen_q   <= 1'b1;
          w_loaded_q <= 1'b1;
        end
      end
    end
  end

  // Processed tiles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_cnt_q <= '0;
    end else if (sched_i.rst) begin
      tile_cnt_q <= '0;
    end else if (count_en && tile_cnt_q != config_i.total_tiles) begin
      tile_cnt_q <= tile_cnt_q + 1'b1;
    end
  end

  // Stream flags held until the finish flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_done_q <= 1'b0;
      r_done_q <= 1'b0;
    end else if (sched_i.finished) begin
      z_done_q <= 1'b0;
      r_done_q <= 1'b0;
    end else begin
      if (count_en && tile_cnt_q == config_i.total_tiles) begin
        z_done_q <= 1'b1;
      end
      // Reduction trails the output stream by a cycle
      r_done_q <= r_done_q | (z_done_q & (config_i.red_op != mm_cfg_pkg::RED_NONE));
    end
  end

  assign w_loaded_o               = w_loaded_q;
  assign flags_o.z_done           = z_done_q;
  assign flags_o.r_done           = r_done_q;
  assign flags_o.tiles_seen_valid = tile_cnt_q != '0;
  assign tiles_o                  = tile_cnt_q;

endmodule

// File: mm_ctrl.sv
// Job controller
module mm_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mm_ctrl_pkg::periph_req_t   periph_req_i,
  output mm_ctrl_pkg::periph_rsp_t   periph_rsp_o,
  input  logic                       w_loaded_i,
  input  mm_ctrl_pkg::stream_flags_t flags_i,
  input  mm_cfg_pkg::tile_cnt_t      tiles_i,
  output mm_cfg_pkg::mm_config_t     config_o,
  output mm_ctrl_pkg::sched_ctrl_t   sched_o,
  output logic                       busy_o,
  output logic                       clear_o,
  output logic                       evt_done_o
);

  mm_ctrl_pkg::ctrl_state_e state_q;
  mm_ctrl_pkg::ctrl_state_e state_d;
  mm_cfg_pkg::mm_config_t   job_cfg;
  mm_cfg_pkg::mm_config_t   tiler_cfg;
  mm_cfg_pkg::mm_config_t   cfg_q;
  mm_cfg_pkg::tile_cnt_t    tiles_rep;
  logic                     cfg_wr;
  logic                     start;
  logic                     tiler_valid;
  logic                     setback;
  logic                     pending_q;
  logic                     latch_clear;
  logic                     job_done;
  logic                     finished;

  mm_regfile i_regfile (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .busy_i       ( busy_o       ),
    .done_i       ( finished     ),
    .tiles_i      ( tiles_rep    ),
    .job_cfg_o    ( job_cfg      ),
    .cfg_wr_o     ( cfg_wr       ),
    .start_o      ( start        )
  );

  mm_tiler i_tiler (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .cfg_wr_i  ( cfg_wr      ),
    .setback_i ( setback     ),
    .job_cfg_i ( job_cfg     ),
    .valid_o   ( tiler_valid ),
    .config_o  ( tiler_cfg   )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mm_ctrl_pkg::ST_LATCH_RST;
    end else begin
      state_q <= state_d;
    end
  end

  // Pending trigger, a trigger while busy waits for the next idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (latch_clear) begin
      pending_q <= 1'b0;
    end else if (start) begin
      pending_q <= 1'b1;
    end else if (setback) begin
      pending_q <= 1'b0;
    end
  end

  // Job config frozen at launch, so reprogramming cannot disturb it
  always_ff @(posedge clk_i) begin
    if (setback) begin
      cfg_q <= tiler_cfg;
    end
  end

  // Output stream done, plus reduction stream when one is running
  assign job_done = flags_i.z_done &
                    ((cfg_q.red_op == mm_cfg_pkg::RED_NONE) | flags_i.r_done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      mm_ctrl_pkg::ST_LATCH_RST: state_d = mm_ctrl_pkg::ST_IDLE;
      mm_ctrl_pkg::ST_IDLE: begin
        if (pending_q && tiler_valid) begin
          state_d = mm_ctrl_pkg::ST_STARTING;
        end
      end
      mm_ctrl_pkg::ST_STARTING: begin
        if (w_loaded_i) begin
          state_d = mm_ctrl_pkg::ST_COMPUTING;
        end
      end
      mm_ctrl_pkg::ST_COMPUTING: begin
        if (job_done) begin
          state_d = mm_ctrl_pkg::ST_FINISHED;
        end
      end
      mm_ctrl_pkg::ST_FINISHED: state_d = mm_ctrl_pkg::ST_IDLE;
      default: state_d = mm_ctrl_pkg::ST_IDLE;
    endcase
  end

  assign latch_clear = state_q == mm_ctrl_pkg::ST_LATCH_RST;
  assign finished    = state_q == mm_ctrl_pkg::ST_FINISHED;
  assign setback     = (state_q == mm_ctrl_pkg::ST_IDLE) &&
                       (state_d == mm_ctrl_pkg::ST_STARTING);

  // No tiles counted means the job produced nothing
  assign tiles_rep = flags_i.tiles_seen_valid ? tiles_i : '0;

  assign sched_o.first_load = state_q == mm_ctrl_pkg::ST_STARTING;
  assign sched_o.rst        = finished;
  assign sched_o.finished   = finished;

  assign busy_o     = (state_q == mm_ctrl_pkg::ST_STARTING) ||
                      (state_q == mm_ctrl_pkg::ST_COMPUTING);
  assign evt_done_o = finished;
  assign clear_o    = latch_clear | finished;
  assign config_o   = cfg_q;

endmodule

// File: mm_tiler.sv
// Job tiler
`include "mm_consts.svh"

module mm_tiler (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cfg_wr_i,
  input  logic                   setback_i,
  input  mm_cfg_pkg::mm_config_t job_cfg_i,
  output logic                   valid_o,
  output mm_cfg_pkg::mm_config_t config_o
);

  localparam int unsigned XShift = $clog2(`MM_WIDTH);
  localparam int unsigned WShift = $clog2(`MM_TILE);
  localparam int unsigned KShift = $clog2(`MM_HEIGHT);
  localparam int unsigned ExtW   = `MM_SIZE_W + 1;

  logic [ExtW-1:0]        m_ceil;
  logic [ExtW-1:0]        n_ceil;
  logic [ExtW-1:0]        k_ceil;
  mm_cfg_pkg::mm_config_t s1_d;
  mm_cfg_pkg::mm_config_t s1_q;
  mm_cfg_pkg::mm_config_t s2_d;
  mm_cfg_pkg::mm_config_t s2_q;
  logic                   s1_vld_q;
  logic                   valid_q;

  // Round up before the shift, spare bit keeps the carry
  assign m_ceil = {1'b0, job_cfg_i.m_size} + ExtW'(`MM_WIDTH - 1);
  assign n_ceil = {1'b0, job_cfg_i.n_size} + ExtW'(`MM_TILE - 1);
  assign k_ceil = {1'b0, job_cfg_i.k_size} + ExtW'(`MM_HEIGHT - 1);

  // Stage 1: ceiling division and remainders
  always_comb begin
    s1_d             = job_cfg_i;
    s1_d.x_tiles     = mm_cfg_pkg::tile_cnt_t'(m_ceil >> XShift);
    s1_d.w_tiles     = mm_cfg_pkg::tile_cnt_t'(n_ceil >> WShift);
    s1_d.k_tiles     = mm_cfg_pkg::tile_cnt_t'(k_ceil >> KShift);
    s1_d.total_tiles = '0;
    s1_d.m_left      = job_cfg_i.m_size[XShift-1:0];
    s1_d.n_left      = job_cfg_i.n_size[WShift-1:0];
    s1_d.k_left      = job_cfg_i.k_size[KShift-1:0];
  end

  // Stage 2: output tiles over both axes
  always_comb begin
    s2_d             = s1_q;
    s2_d.total_tiles = s1_q.x_tiles * s1_q.w_tiles;
  end

  always_ff @(posedge clk_i) begin
    if (cfg_wr_i) begin
      s1_q <= s1_d;
    end
    if (s1_vld_q) begin
      s2_q <= s2_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_vld_q <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      s1_vld_q <= cfg_wr_i;
      // Fresh config survives a setback in the same cycle
      if (s1_vld_q) begin
        valid_q <= 1'b1;
      end else if (setback_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign valid_o  = valid_q;
  assign config_o = s2_q;

endmodule

// File: mm_regfile.sv
// Job register slave
`include "mm_consts.svh"

module mm_regfile (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  mm_ctrl_pkg::periph_req_t periph_req_i,
  output mm_ctrl_pkg::periph_rsp_t periph_rsp_o,
  input  logic                     busy_i,
  input  logic                     done_i,
  input  mm_cfg_pkg::tile_cnt_t    tiles_i,
  output mm_cfg_pkg::mm_config_t   job_cfg_o,
  output logic                     cfg_wr_o,
  output logic                     start_o
);

  mm_cfg_pkg::dim_t       m_q;
  mm_cfg_pkg::dim_t       n_q;
  mm_cfg_pkg::dim_t       k_q;
  mm_cfg_pkg::red_op_e    red_q;
  mm_cfg_pkg::tile_cnt_t  tiles_q;
  logic                   done_q;
  logic                   wr_en;
  logic                   rd_en;
  logic                   cfg_hit;
  logic                   rsp_valid_q;
  mm_ctrl_pkg::reg_data_t rdata_d;
  mm_ctrl_pkg::reg_data_t rdata_q;

  assign wr_en   = periph_req_i.req & periph_req_i.we;
  assign rd_en   = periph_req_i.req & ~periph_req_i.we;
  // Writes that change the job shape
  assign cfg_hit = periph_req_i.addr inside {`MM_REG_M, `MM_REG_N, `MM_REG_K, `MM_REG_RED};

  // Job registers, updated at the write edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_q   <= '0;
      n_q   <= '0;
      k_q   <= '0;
      red_q <= mm_cfg_pkg::RED_NONE;
    end else if (wr_en) begin
      case (periph_req_i.addr)
        `MM_REG_M:   m_q   <= periph_req_i.wdata[`MM_SIZE_W-1:0];
        `MM_REG_N:   n_q   <= periph_req_i.wdata[`MM_SIZE_W-1:0];
        `MM_REG_K:   k_q   <= periph_req_i.wdata[`MM_SIZE_W-1:0];
        `MM_REG_RED: red_q <= mm_cfg_pkg::red_op_e'(periph_req_i.wdata[1:0]);
        default: ;
      endcase
    end
  end

  // Strobes come one cycle late so the new values are already in place
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_wr_o <= 1'b0;
      start_o  <= 1'b0;
    end else begin
      cfg_wr_o <= wr_en & cfg_hit;
      start_o  <= wr_en & (periph_req_i.addr == `MM_REG_TRIGGER);
    end
  end

  // Status side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tiles_q <= '0;
      done_q  <= 1'b0;
    end else begin
      if (done_i) begin
        tiles_q <= tiles_i;
      end
      // Set wins over a status read in the same cycle
      if (done_i) begin
        done_q <= 1'b1;
      end else if (rd_en && periph_req_i.addr == `MM_REG_STATUS) begin
        done_q <= 1'b0;
      end
    end
  end

  // Read mux, zero extended
  always_comb begin
    rdata_d = '0;
    case (periph_req_i.addr)
      `MM_REG_M:      rdata_d[`MM_SIZE_W-1:0] = m_q;
      `MM_REG_N:      rdata_d[`MM_SIZE_W-1:0] = n_q;
      `MM_REG_K:      rdata_d[`MM_SIZE_W-1:0] = k_q;
      `MM_REG_RED:    rdata_d[1:0] = red_q;
      `MM_REG_STATUS: rdata_d[1:0] = {done_q, busy_i};
      `MM_REG_TILES:  rdata_d[`MM_SIZE_W-1:0] = tiles_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_en;
    end
  end

  // Read data only matters while valid
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign periph_rsp_o.valid = rsp_valid_q;
  assign periph_rsp_o.rdata = rdata_q;

  // Sizes and mode only, tiling comes later
  always_comb begin
    job_cfg_o        = '0;
    job_cfg_o.m_size = m_q;
    job_cfg_o.n_size = n_q;
    job_cfg_o.k_size = k_q;
    job_cfg_o.red_op = red_q;
  end

endmodule

// File: mm_ctrl_pkg.sv
// Control and flag types
`include "mm_consts.svh"

package mm_ctrl_pkg;

  typedef logic [`MM_ADDR_W-1:0] reg_addr_t;
  typedef logic [`MM_DATA_W-1:0] reg_data_t;

  // Peripheral request, one-cycle strobe on req
  typedef struct packed {
    logic      req;
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } periph_req_t;

  // Registered read answer
  typedef struct packed {
    logic      valid;
    reg_data_t rdata;
  } periph_rsp_t;

  // Controller to engine
  typedef struct packed {
    logic first_load;
    logic rst;
    logic finished;
  } sched_ctrl_t;

  // Engine to controller, held as levels
  typedef struct packed {
    logic z_done;
    logic r_done;
    logic tiles_seen_valid;
  } stream_flags_t;

  typedef enum logic [2:0] {
    ST_LATCH_RST = 3'd0,
    ST_IDLE      = 3'd1,
    ST_STARTING  = 3'd2,
    ST_COMPUTING = 3'd3,
    ST_FINISHED  = 3'd4
  } ctrl_state_e;

endpackage

// File: mm_cfg_pkg.sv
// Job configuration types
`include "mm_consts.svh"

package mm_cfg_pkg;

  // One matrix dimension
  typedef logic [`MM_SIZE_W-1:0] dim_t;

  // Tile counts share the dimension width
  typedef logic [`MM_SIZE_W-1:0] tile_cnt_t;

  // Reduction applied on the output stream
  typedef enum logic [1:0] {
    RED_NONE = 2'd0,
    RED_SUM  = 2'd1,
    RED_MAX  = 2'd2
  } red_op_e;

  // Programmed sizes plus the derived tiling
  typedef struct packed {
    dim_t                             m_size;
    dim_t                             n_size;
    dim_t                             k_size;
    red_op_e                          red_op;
    tile_cnt_t                        x_tiles;
    tile_cnt_t                        w_tiles;
    tile_cnt_t                        k_tiles;
    tile_cnt_t                        total_tiles;
    // Leftovers, zero when the size divides evenly
    logic [$clog2(`MM_WIDTH)-1:0]     m_left;
    logic [$clog2(`MM_TILE)-1:0]      n_left;
    logic [$clog2(`MM_HEIGHT)-1:0]    k_left;
  } mm_config_t;

endpackage

// File: mm_consts.svh
// Accelerator geometry and register map
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// Array geometry
`define MM_HEIGHT     4
`define MM_WIDTH      8
`define MM_PIPE_REGS  3
// One row tile covers every pipeline stage of a column
`define MM_TILE       ((`MM_PIPE_REGS + 1) * `MM_HEIGHT)

// Datapath widths
`define MM_SIZE_W     16
`define MM_ADDR_W     3
`define MM_DATA_W     32

// Register indices
`define MM_REG_M       3'd0
`define MM_REG_N       3'd1
`define MM_REG_K       3'd2
`define MM_REG_RED     3'd3
`define MM_REG_TRIGGER 3'd4
`define MM_REG_STATUS  3'd5
`define MM_REG_TILES   3'd6

`endif
